// File: Makefile
TOP := tb_sram_subsystem
OBJ := obj_dir

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module $(TOP) -Mdir $(OBJ)

run: build
	./$(OBJ)/V$(TOP) | tee sim.log
	@grep -q "^Regression passed$$" sim.log

lint:
	verilator --lint-only -Wall +incdir+logic \
		logic/sram_pkg.sv logic/req_splitter.sv logic/half_op_fifo.sv \
		logic/sram_sequencer.sv logic/sram_subsystem.sv \
		--top-module sram_subsystem

clean:
	rm -rf $(OBJ) sim.log

// File: compile.f
+incdir+logic
logic/sram_pkg.sv
logic/req_splitter.sv
logic/half_op_fifo.sv
logic/sram_sequencer.sv
logic/sram_subsystem.sv
test/sram_model.sv
test/tb_sram_subsystem.sv

// File: logic/half_op_fifo.sv
`default_nettype none
`timescale 1ns/1ps

`include "sram_macros.svh"

module half_op_fifo import sram_pkg::*; (
	input wire i_clock,
	input wire i_reset,
	input logic i_push,
	input half_op_t i_op,
	output logic o_valid,
	output half_op_t o_head,
	input logic i_pop,
	output logic o_credit
);
	localparam int DEPTH = `SRAM_FIFO_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

	half_op_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_pop;

	assign o_valid = (count != '0);
	assign o_head = mem[rd_ptr];
	assign do_pop = i_pop && o_valid;

	always_ff @(posedge i_clock) begin
		if (i_push)
			mem[wr_ptr] <= i_op;
	end

	// Pointers wrap at the depth, which need not be a power of two.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (i_push)
				wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
		end
	end

	// Occupancy, push and pop may land in the same cycle.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			count <= '0;
		end else begin
			case ({i_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// One credit back to the splitter for each freed entry.
	always_ff @(posedge i_clock) begin
		if (i_reset)
			o_credit <= 1'b0;
		else
			o_credit <= do_pop;
	end

	a_no_overflow: assert property (@(posedge i_clock) disable iff (i_reset)
		i_push |-> (count < CNT_W'(DEPTH)) || i_pop);

	a_no_underflow: assert property (@(posedge i_clock) disable iff (i_reset)
		i_pop |-> o_valid);

endmodule

`default_nettype wire

// File: logic/req_splitter.sv
`default_nettype none
`timescale 1ns/1ps

`include "sram_macros.svh"

module req_splitter import sram_pkg::*; (
	input wire i_clock,
	input wire i_reset,
	input logic i_req_valid,
	input host_req_t i_req,
	output logic o_req_credit,
	output logic o_half_push,
	output half_op_t o_half_op,
	input logic i_half_credit
);
	localparam int DEPTH = `SRAM_FIFO_DEPTH;
	localparam int CRED_W = $clog2(DEPTH + 1);

	host_req_t req_q;
	logic busy;
	logic phase;
	logic [CRED_W-1:0] credits;
	logic [17:0] word_base;

	// Word address in half-word units, always even.
	assign word_base = {req_q.addr[18:2], 1'b0};

	// Push whenever a request is held and the buffer has room.
	assign o_half_push = busy && (credits != '0);

	always_comb begin
		o_half_op.write = req_q.write;
		o_half_op.high = phase;
		o_half_op.addr = word_base + 18'(phase);
		o_half_op.data = phase ? req_q.data[31:16] : req_q.data[15:0];
	end

	// Request register and phase.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			busy <= 1'b0;
			phase <= 1'b0;
		end else if (i_req_valid) begin
			busy <= 1'b1;
			phase <= 1'b0;
		end else if (o_half_push) begin
			phase <= ~phase;
			// High half gone, request register is free.
			if (phase)
				busy <= 1'b0;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_req_valid)
			req_q <= i_req;
	end

	// Host credit returns the cycle after the high half leaves.
	always_ff @(posedge i_clock) begin
		if (i_reset)
			o_req_credit <= 1'b0;
		else
			o_req_credit <= o_half_push && phase;
	end

	// Buffer credits: one spent per push, one back per FIFO pop.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			credits <= CRED_W'(DEPTH);
		end else begin
			case ({o_half_push, i_half_credit})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	// The host only issues while it holds a credit, so never into a busy splitter.
	a_no_req_while_busy: assert property (@(posedge i_clock) disable iff (i_reset)
		i_req_valid |-> !busy);

	a_no_push_without_credit: assert property (@(posedge i_clock) disable iff (i_reset)
		o_half_push |-> (credits != '0) && (credits <= CRED_W'(DEPTH)));

endmodule

`default_nettype wire

// File: logic/sram_macros.svh
`ifndef SRAM_MACROS_SVH
`define SRAM_MACROS_SVH

// Half-op entries in the buffer, also the splitter's starting credit count.
`define SRAM_FIFO_DEPTH 4

// Clock cycles in one half-word SRAM access, at least 3.
`define SRAM_HALF_CYCLES 4

// Count within a half access at which read data is captured.
`define SRAM_SAMPLE_CYCLE 2

// Request credits the host holds after reset.
`define SRAM_HOST_CREDITS 1

`endif

// File: logic/sram_pkg.sv
`default_nettype none

package sram_pkg;

	// One 32-bit host request.
	typedef struct packed {
		logic write;
		logic [31:0] addr;
		logic [31:0] data;
	} host_req_t;

	// One half-word SRAM operation.
	// Low half goes to the even address, high half to the odd one.
	typedef struct packed {
		logic write;
		logic high;
		logic [17:0] addr;
		logic [15:0] data;
	} half_op_t;

	// Read response back to the host.
	typedef struct packed {
		logic [31:0] data;
	} host_rsp_t;

	// SRAM pins, strobes active low.
	// The data bus is split into output, output enable and input.
	typedef struct packed {
		logic [17:0] addr;
		logic ce_n;
		logic oe_n;
		logic we_n;
		logic lb_n;
		logic ub_n;
		logic [15:0] dq_out;
		logic dq_oe;
	} sram_pins_t;

endpackage

`default_nettype wire

// File: logic/sram_sequencer.sv
`default_nettype none
`timescale 1ns/1ps

`include "sram_macros.svh"

module sram_sequencer import sram_pkg::*; (
	input wire i_clock,
	input wire i_reset,
	input logic i_valid,
	input half_op_t i_head,
	output logic o_pop,
	output sram_pins_t o_sram,
	input logic [15:0] i_sram_dq,
	output logic o_rsp_valid,
	output host_rsp_t o_rsp
);
	localparam int HALF = `SRAM_HALF_CYCLES;
	localparam int CNT_W = $clog2(HALF);
	localparam logic [CNT_W-1:0] LAST = CNT_W'(HALF - 1);
	localparam logic [CNT_W-1:0] SAMPLE = CNT_W'(`SRAM_SAMPLE_CYCLE);
	// Write enable is held low for counts 0 and 1.
	localparam logic [CNT_W-1:0] WE_END = CNT_W'(2);

	logic [CNT_W-1:0] count;
	logic is_write;
	logic is_read;
	logic last_cycle;
	logic sample;
	logic [15:0] low_q;

	assign is_write = i_valid && i_head.write;
	assign is_read = i_valid && !i_head.write;
	assign last_cycle = i_valid && (count == LAST);
	assign sample = is_read && (count == SAMPLE);

	// Entry leaves the FIFO in the last cycle of its access.
	assign o_pop = last_cycle;

	// Access counter. It restarts at 0 for a back-to-back entry.
	always_ff @(posedge i_clock) begin
		if (i_reset)
			count <= '0;
		else if (!i_valid || last_cycle)
			count <= '0;
		else
			count <= count + 1'b1;
	end

	// Pin shaping.
	always_comb begin
		o_sram.addr = i_valid ? i_head.addr : '0;
		o_sram.ce_n = !i_valid;
		// Output enable covers the whole read access.
		o_sram.oe_n = !is_read;
		// SRAM stores on the rising edge of write enable.
		o_sram.we_n = !(is_write && (count < WE_END));
		o_sram.lb_n = 1'b0;
		o_sram.ub_n = 1'b0;
		o_sram.dq_out = i_head.data;
		o_sram.dq_oe = is_write;
	end

	// Low read half waits here for its partner.
	always_ff @(posedge i_clock) begin
		if (sample && !i_head.high)
			low_q <= i_sram_dq;
	end

	// Full word is put together when the high half is sampled.
	always_ff @(posedge i_clock) begin
		if (sample && i_head.high)
			o_rsp.data <= {i_sram_dq, low_q};
	end

	always_ff @(posedge i_clock) begin
		if (i_reset)
			o_rsp_valid <= 1'b0;
		else
			o_rsp_valid <= last_cycle && is_read && i_head.high;
	end

	a_strobes_exclusive: assert property (@(posedge i_clock) disable iff (i_reset)
		!(!o_sram.we_n && !o_sram.oe_n));

	// The FIFO head must not move under an access in progress.
	a_head_stable: assert property (@(posedge i_clock) disable iff (i_reset)
		(i_valid && !o_pop) |=> i_valid && $stable(i_head));

	// A high half always follows its own low half.
	a_half_order: assert property (@(posedge i_clock) disable iff (i_reset)
		(o_pop && !i_head.high) |=> !i_valid || i_head.high);

endmodule

`default_nettype wire

// File: logic/sram_subsystem.sv
`default_nettype none
`timescale 1ns/1ps

module sram_subsystem import sram_pkg::*; (
	input wire i_clock,
	input wire i_reset,
	input logic i_req_valid,
	input host_req_t i_req,
	output logic o_req_credit,
	output logic o_rsp_valid,
	output host_rsp_t o_rsp,
	output sram_pins_t o_sram,
	input logic [15:0] i_sram_dq
);
	logic half_push;
	half_op_t half_op;
	logic half_credit;
	logic fifo_valid;
	half_op_t fifo_head;
	logic fifo_pop;

	// Producer.
	req_splitter req_splitter_inst (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_req_valid(i_req_valid),
		.i_req(i_req),
		.o_req_credit(o_req_credit),
		.o_half_push(half_push),
		.o_half_op(half_op),
		.i_half_credit(half_credit)
	);

	// Buffer.
	half_op_fifo half_op_fifo_inst (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_push(half_push),
		.i_op(half_op),
		.o_valid(fifo_valid),
		.o_head(fifo_head),
		.i_pop(fifo_pop),
		.o_credit(half_credit)
	);

	// Consumer, owns the SRAM pins.
	sram_sequencer sram_sequencer_inst (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_valid(fifo_valid),
		.i_head(fifo_head),
		.o_pop(fifo_pop),
		.o_sram(o_sram),
		.i_sram_dq(i_sram_dq),
		.o_rsp_valid(o_rsp_valid),
		.o_rsp(o_rsp)
	);

endmodule

`default_nettype wire

// File: test/sram_model.sv
`default_nettype none
`timescale 1ns/1ps

module sram_model import sram_pkg::*; (
	input sram_pins_t i_sram,
	output logic [15:0] o_dq
);
	localparam int WORDS = 1 << 18;

	logic [15:0] mem [0:WORDS-1];
	logic we_n;

	// Power-up contents follow the full 18-bit address.
	initial begin
		for (int a = 0; a < WORDS; a++)
			mem[a] = 16'(a) ^ {2'(a >> 16), 14'h1234};
	end

	assign we_n = i_sram.we_n;

	// Resolved data bus, the controller wins while it drives.
	assign o_dq = i_sram.dq_oe ? i_sram.dq_out :
		(!i_sram.ce_n && !i_sram.oe_n) ? mem[i_sram.addr] : 16'hxxxx;

	// Data is stored when write enable rises.
	always @(posedge we_n) begin
		if (!i_sram.ce_n && i_sram.dq_oe) begin
			if (!i_sram.lb_n)
				mem[i_sram.addr][7:0] <= i_sram.dq_out[7:0];
			if (!i_sram.ub_n)
				mem[i_sram.addr][15:8] <= i_sram.dq_out[15:8];
		end
	end

endmodule

`default_nettype wire

// File: test/tb_sram_subsystem.sv
`default_nettype none
`timescale 1ns/1ps

`include "sram_macros.svh"

module tb_sram_subsystem import sram_pkg::*; ();
	localparam int NUM_RANDOM = 200;
	localparam int NUM_REQUESTS = NUM_RANDOM + 4;
	localparam int WATCHDOG_CYCLES = NUM_REQUESTS * 4 * `SRAM_HALF_CYCLES + 500;
	localparam logic [31:0] WINDOW_BASE = 32'h0000_0400;

	logic clock;
	logic reset;
	logic req_valid;
	host_req_t req;
	logic req_credit;
	logic rsp_valid;
	host_rsp_t rsp;
	sram_pins_t sram_pins;
	logic [15:0] sram_dq;

	int host_credits;
	int issued = 0;
	int reads = 0;
	int writes = 0;
	int credits_back = 0;
	int responses = 0;
	int we_pulses = 0;
	int we_run = 0;
	int data_errors = 0;
	int protocol_errors = 0;
	logic [31:0] lcg_state = 32'd82;
	logic [31:0] shadow [logic [16:0]];
	logic [31:0] exp_q [$];

	sram_subsystem sram_subsystem_inst (
		.i_clock(clock),
		.i_reset(reset),
		.i_req_valid(req_valid),
		.i_req(req),
		.o_req_credit(req_credit),
		.o_rsp_valid(rsp_valid),
		.o_rsp(rsp),
		.o_sram(sram_pins),
		.i_sram_dq(sram_dq)
	);

	sram_model sram_model_inst (
		.i_sram(sram_pins),
		.o_dq(sram_dq)
	);

	always #5 clock = ~clock;

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// Power-up word of the model at one SRAM address.
	function automatic logic [15:0] fill_word(input logic [17:0] a);
		return a[15:0] ^ {a[17:16], 14'h1234};
	endfunction

	// Byte address to the even SRAM address of its low half.
	function automatic logic [17:0] half_base(input logic [31:0] addr);
		return 18'(addr >> 1) & ~18'd1;
	endfunction

	function automatic logic [31:0] ref_read(input logic [31:0] addr);
		logic [17:0] base;
		base = half_base(addr);
		if (shadow.exists(addr[18:2]))
			return shadow[addr[18:2]];
		return {fill_word(base + 18'd1), fill_word(base)};
	endfunction

	task automatic issue_req(input logic is_write, input logic [31:0] addr,
			input logic [31:0] data);
		do
			@(posedge clock);
		while (host_credits == 0);
		req_valid <= 1'b1;
		req.write <= is_write;
		req.addr <= addr;
		req.data <= data;
		if (is_write) begin
			shadow[addr[18:2]] = data;
			writes++;
		end else begin
			exp_q.push_back(ref_read(addr));
			reads++;
		end
		issued++;
		@(posedge clock);
		req_valid <= 1'b0;
	endtask

	// Idle once all credits are home, no read is pending and the SRAM is deselected.
	task automatic wait_idle();
		do
			@(posedge clock);
		while (exp_q.size() != 0 || host_credits != `SRAM_HOST_CREDITS ||
			sram_pins.ce_n !== 1'b1);
	endtask

	task automatic check_placement(input logic [31:0] addr, input logic [31:0] data);
		logic [17:0] base;
		base = half_base(addr);
		assert (sram_model_inst.mem[base] == data[15:0]) else begin
			data_errors++;
			$display("CHECK FAILED mem[%05h]: got %04h, expected %04h",
				base, sram_model_inst.mem[base], data[15:0]);
		end
		assert (sram_model_inst.mem[base + 18'd1] == data[31:16]) else begin
			data_errors++;
			$display("CHECK FAILED mem[%05h]: got %04h, expected %04h",
				base + 18'd1, sram_model_inst.mem[base + 18'd1], data[31:16]);
		end
	endtask

	// Host credit count. One is spent per request and one comes back per credit pulse.
	always @(posedge clock) begin
		int next_credits;
		if (reset) begin
			host_credits <= `SRAM_HOST_CREDITS;
		end else begin
			next_credits = host_credits + (req_credit ? 1 : 0) - (req_valid ? 1 : 0);
			assert (next_credits <= `SRAM_HOST_CREDITS) else begin
				protocol_errors++;
				$display("A credit came back with no request outstanding");
			end
			if (req_credit)
				credits_back++;
			host_credits <= next_credits;
		end
	end

	// Read responses checked against the expected words in issue order.
	always @(posedge clock) begin
		logic [31:0] expected;
		if (!reset && rsp_valid) begin
			assert (exp_q.size() != 0) else begin
				protocol_errors++;
				$display("A read response arrived with no read outstanding");
			end
			if (exp_q.size() != 0) begin
				expected = exp_q.pop_front();
				responses++;
				assert (rsp.data == expected) else begin
					data_errors++;
					$display("CHECK FAILED o_rsp.data: got %08h, expected %08h",
						rsp.data, expected);
				end
			end
		end
	end

	// Strobe shape on the SRAM pins.
	always @(posedge clock) begin
		if (!reset) begin
			assert (sram_pins.we_n || sram_pins.oe_n) else begin
				protocol_errors++;
				$display("Write enable and output enable were low together");
			end
			if (!sram_pins.we_n) begin
				we_run++;
			end else if (we_run != 0) begin
				assert (we_run == 2) else begin
					protocol_errors++;
					$display("CHECK FAILED we_n low cycles: got %0h, expected 2", we_run);
				end
				we_pulses++;
				we_run = 0;
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Regression failed");
		$finish;
	end

	initial begin
		logic [31:0] rnd;
		logic [31:0] addr;
		logic [31:0] data;
		clock = 1'b0;
		reset = 1'b1;
		req_valid = 1'b0;
		req = '0;
		repeat (2) @(posedge clock);
		reset <= 1'b0;

		// Quiet outputs after reset.
		repeat (3) begin
			@(posedge clock);
			assert (!rsp_valid && !req_credit) else begin
				protocol_errors++;
				$display("Response or credit seen before any request");
			end
			assert (sram_pins.we_n && sram_pins.oe_n && sram_pins.ce_n) else begin
				protocol_errors++;
				$display("SRAM strobes not idle after reset");
			end
		end
		assert (host_credits == `SRAM_HOST_CREDITS) else begin
			protocol_errors++;
			$display("CHECK FAILED host_credits: got %0h, expected %0h",
				host_credits, `SRAM_HOST_CREDITS);
		end

		// Write then read back, and look at where the halves landed.
		issue_req(1'b1, 32'h0000_0420, 32'hCAFE_1234);
		issue_req(1'b0, 32'h0000_0420, '0);
		wait_idle();
		check_placement(32'h0000_0420, 32'hCAFE_1234);
		issue_req(1'b1, 32'h0000_04F8, 32'h0BAD_F00D);
		issue_req(1'b0, 32'h0000_04F8, '0);

		for (int i = 0; i < NUM_RANDOM; i++) begin
			lcg_state = lcg_next(lcg_state);
			rnd = lcg_state;
			addr = WINDOW_BASE + {24'h0, rnd[23:18], 2'b00};
			lcg_state = lcg_next(lcg_state);
			data = lcg_state;
			issue_req(rnd[30], addr, data);
		end

		wait_idle();
		repeat (2) @(posedge clock);
		assert (credits_back == issued) else begin
			protocol_errors++;
			$display("CHECK FAILED o_req_credit count: got %0h, expected %0h",
				credits_back, issued);
		end
		assert (responses == reads) else begin
			protocol_errors++;
			$display("CHECK FAILED o_rsp_valid count: got %0h, expected %0h",
				responses, reads);
		end
		assert (we_pulses == 2 * writes) else begin
			protocol_errors++;
			$display("CHECK FAILED we_n pulse count: got %0h, expected %0h",
				we_pulses, 2 * writes);
		end

		$display("Errors: %0d data, %0d protocol", data_errors, protocol_errors);
		if (data_errors == 0 && protocol_errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire
